//--- verilog/drone_pkg.sv
// drone throttle path definitions
package drone_pkg;

	// width of one throttle value from the receiver
	localparam int throttle_width = 8;

	// history sum must hold 32 x 255
	localparam int sum_width = 13;

	// moving average window
	localparam int hist_depth = 32;
	// log2 of hist_depth, divides the sum down to an average
	localparam int hist_shift = 5;

	// throttle value as seen by every stage
	typedef logic [throttle_width-1:0] throttle_t;

	// below this the motors are treated as idle
	localparam throttle_t idle_default = 8'd10;
	// full scale, no clamping after reset
	localparam throttle_t ceiling_default = 8'd255;

	// configuration register map
	localparam logic [1:0] addr_idle = 2'd0;
	localparam logic [1:0] addr_ceiling = 2'd1;
	localparam logic [1:0] addr_bypass = 2'd2;

	// us_clk cycles per pwm frame
	// 256 gives one count per throttle step
	localparam int pwm_period = 256;

endpackage

//--- verilog/limiter_if.sv
// limiter handshake bus
`timescale 1ns/100ps

interface limiter_if;

	// one-cycle request, only while the limiter waits
	logic start;
	// limiter busy in buffering, adding, averaging
	logic active;
	// one-cycle done pulse, result valid here
	logic complete;

	// throttle sample handed to the limiter
	drone_pkg::throttle_t sample;
	// smoothed throttle, held until next completion
	drone_pkg::throttle_t result;

	// input port side
	modport source (
		output start,
		output sample,
		input  active,
		input  complete,
		input  result
	);

	// limiter side
	modport sink (
		input  start,
		input  sample,
		output active,
		output complete,
		output result
	);

endinterface

//--- verilog/throttle_input_port.sv
// four-phase throttle input port
`timescale 1ns/100ps

module throttle_input_port (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 in_req,
	input  drone_pkg::throttle_t in_throttle,
	output logic                 in_ack,
	limiter_if.source            lim
);

	// idle: wait for a request
	// busy: limiter working on the sample
	// acked: ack high, wait for req to drop
	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_busy  = 2'd1,
		st_acked = 2'd2
	} port_state_t;

	port_state_t state;

	// new request only while ack is low and limiter is free
	logic take_req;

	assign take_req = (state == st_idle) && in_req && !lim.active;

	// handshake controller
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= st_idle;
			lim.start <= 1'b0;
			in_ack <= 1'b0;
		end else begin
			// start is a single-cycle pulse
			lim.start <= 1'b0;
			case (state)
				st_idle: begin
					if (take_req) begin
						lim.start <= 1'b1;
						state <= st_busy;
					end
				end
				st_busy: begin
					// ack on the edge after complete
					if (lim.complete) begin
						in_ack <= 1'b1;
						state <= st_acked;
					end
				end
				st_acked: begin
					// source released req, close the cycle
					if (!in_req) begin
						in_ack <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					in_ack <= 1'b0;
					state <= st_idle;
				end
			endcase
		end
	end

	// capture the sample while req holds it stable
	always_ff @(posedge us_clk) begin
		if (take_req)
			lim.sample <= in_throttle;
	end

endmodule

//--- verilog/limiter_config.sv
// limiter configuration registers
`timescale 1ns/100ps

module limiter_config (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 cfg_write,
	input  logic [1:0]           cfg_addr,
	input  drone_pkg::throttle_t cfg_data,
	output drone_pkg::throttle_t idle_threshold,
	output drone_pkg::throttle_t ceiling,
	output logic                 bypass
);

	// address decode, one strobe per register
	logic wr_idle;
	logic wr_ceiling;
	logic wr_bypass;

	assign wr_idle = cfg_write && (cfg_addr == drone_pkg::addr_idle);
	assign wr_ceiling = cfg_write && (cfg_addr == drone_pkg::addr_ceiling);
	// address 3 matches none of these and is dropped
	assign wr_bypass = cfg_write && (cfg_addr == drone_pkg::addr_bypass);

	// idle threshold
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			idle_threshold <= drone_pkg::idle_default;
		else if (wr_idle)
			idle_threshold <= cfg_data;
	end

	// throttle ceiling for the motor stage
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			ceiling <= drone_pkg::ceiling_default;
		else if (wr_ceiling)
			ceiling <= cfg_data;
	end

	// bypass skips the average, history keeps filling
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			bypass <= 1'b0;
		else if (wr_bypass)
			// only bit 0 is meaningful
			bypass <= cfg_data[0];
	end

endmodule

//--- verilog/throttle_change_limiter.sv
// moving average throttle limiter
`timescale 1ns/100ps

module throttle_change_limiter (
	input  logic                 us_clk,
	input  logic                 resetn,
	limiter_if.sink              lim,
	input  drone_pkg::throttle_t idle_threshold,
	input  logic                 bypass
);

	// one-hot sequence, waiting then four working steps
	typedef enum logic [4:0] {
		st_waiting   = 5'b00001,
		st_buffering = 5'b00010,
		st_adding    = 5'b00100,
		st_averaging = 5'b01000,
		st_complete  = 5'b10000
	} lim_state_t;

	lim_state_t state;
	lim_state_t next_state;

	// history, entry 0 is the newest sample
	drone_pkg::throttle_t hist [drone_pkg::hist_depth];

	// sample held for the whole sequence
	drone_pkg::throttle_t latched;
	logic [drone_pkg::sum_width-1:0] hist_sum;
	logic [drone_pkg::sum_width-1:0] sum_q;

	// sequence advance
	always_comb begin
		next_state = state;
		case (state)
			st_waiting:   if (lim.start) next_state = st_buffering;
			st_buffering: next_state = st_adding;
			st_adding:    next_state = st_averaging;
			st_averaging: next_state = st_complete;
			st_complete:  next_state = st_waiting;
			default:      next_state = st_waiting;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= st_waiting;
			lim.complete <= 1'b0;
		end else begin
			state <= next_state;
			// complete lands one edge after the complete state
			lim.complete <= (state == st_complete);
		end
	end

	// busy in buffering, adding and averaging
	assign lim.active = state[1] | state[2] | state[3];

	// history update, zeroed by reset and by idle throttle
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < drone_pkg::hist_depth; i++)
				hist[i] <= '0;
		end else if (state == st_buffering) begin
			if (latched < idle_threshold) begin
				// idle, drop the history so the motors stop now
				for (int i = 0; i < drone_pkg::hist_depth; i++)
					hist[i] <= '0;
			end else begin
				hist[0] <= latched;
				for (int i = 1; i < drone_pkg::hist_depth; i++)
					hist[i] <= hist[i-1];
			end
		end
	end

	// full adder tree over the window
	always_comb begin
		hist_sum = '0;
		for (int i = 0; i < drone_pkg::hist_depth; i++)
			hist_sum = hist_sum + drone_pkg::sum_width'(hist[i]);
	end

	// sample, sum and result pipeline
	always_ff @(posedge us_clk) begin
		if (state == st_waiting && lim.start)
			latched <= lim.sample;
		if (state == st_adding)
			sum_q <= hist_sum;
		if (state == st_averaging) begin
			// bypass passes the raw sample through
			if (bypass)
				lim.result <= latched;
			else
				lim.result <= drone_pkg::throttle_t'(sum_q >> drone_pkg::hist_shift);
		end
	end

endmodule

//--- verilog/motor_pwm.sv
// motor throttle clamp and pwm
`timescale 1ns/100ps

module motor_pwm (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 load,
	input  drone_pkg::throttle_t value,
	input  drone_pkg::throttle_t ceiling,
	output drone_pkg::throttle_t motor_throttle,
	output logic                 pwm_out
);

	// free-running position inside the pwm frame
	logic [$clog2(drone_pkg::pwm_period)-1:0] period_cnt;
	// duty in use for the current frame
	drone_pkg::throttle_t duty;
	logic period_end;
	drone_pkg::throttle_t clamped;

	// never command more than the ceiling
	assign clamped = (value > ceiling) ? ceiling : value;

	assign period_end = (period_cnt == drone_pkg::pwm_period - 1);

	// motor throttle register, loaded on limiter complete
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			motor_throttle <= '0;
		else if (load)
			motor_throttle <= clamped;
	end

	// period counter and duty update at the frame boundary
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			period_cnt <= '0;
			duty <= '0;
		end else begin
			if (period_end) begin
				period_cnt <= '0;
				// new duty only between frames, no glitched pulse
				duty <= motor_throttle;
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
		end
	end

	// high for duty counts of each frame
	assign pwm_out = (period_cnt < duty);

endmodule

//--- verilog/throttle_path_top.sv
// throttle path top level
`timescale 1ns/100ps

module throttle_path_top (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 in_req,
	output logic                 in_ack,
	input  drone_pkg::throttle_t in_throttle,
	input  logic                 cfg_write,
	input  logic [1:0]           cfg_addr,
	input  drone_pkg::throttle_t cfg_data,
	output drone_pkg::throttle_t motor_throttle,
	output logic                 pwm_out
);

	// configuration fan-out
	drone_pkg::throttle_t idle_threshold;
	drone_pkg::throttle_t ceiling;
	logic bypass;

	// port to limiter handshake
	limiter_if lim_bus ();

	throttle_input_port throttle_input_port_i (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.in_req      (in_req),
		.in_throttle (in_throttle),
		.in_ack      (in_ack),
		.lim         (lim_bus.source)
	);

	limiter_config limiter_config_i (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.cfg_write      (cfg_write),
		.cfg_addr       (cfg_addr),
		.cfg_data       (cfg_data),
		.idle_threshold (idle_threshold),
		.ceiling        (ceiling),
		.bypass         (bypass)
	);

	throttle_change_limiter throttle_change_limiter_i (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.lim            (lim_bus.sink),
		.idle_threshold (idle_threshold),
		.bypass         (bypass)
	);

	// complete doubles as the motor load strobe
	motor_pwm motor_pwm_i (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.load           (lim_bus.complete),
		.value          (lim_bus.result),
		.ceiling        (ceiling),
		.motor_throttle (motor_throttle),
		.pwm_out        (pwm_out)
	);

endmodule

//--- verification/throttle_model.svh
// throttle path reference model
`ifndef THROTTLE_MODEL_SVH
`define THROTTLE_MODEL_SVH

// model history, index 0 holds the newest sample
int ref_hist [drone_pkg::hist_depth];
// mirror of the configuration registers
int ref_idle;
int ref_ceiling;
int ref_bypass;

// state after reset, empty history and default registers
function automatic void load_defaults();
	for (int i = 0; i < drone_pkg::hist_depth; i++)
		ref_hist[i] = 0;
	ref_idle = drone_pkg::idle_default;
	ref_ceiling = drone_pkg::ceiling_default;
	ref_bypass = 0;
endfunction

// accept one sample and return the expected motor throttle
function automatic int predict_throttle(input int sample);
	int sum;
	int expected;
	if (sample < ref_idle) begin
		// idle throttle wipes the whole window
		for (int i = 0; i < drone_pkg::hist_depth; i++)
			ref_hist[i] = 0;
	end else begin
		for (int i = drone_pkg::hist_depth - 1; i > 0; i--)
			ref_hist[i] = ref_hist[i-1];
		ref_hist[0] = sample;
	end
	sum = 0;
	for (int i = 0; i < drone_pkg::hist_depth; i++)
		sum = sum + ref_hist[i];
	// bypass hands the raw sample on, else the window mean
	expected = (ref_bypass != 0) ? sample : (sum >> drone_pkg::hist_shift);
	if (expected > ref_ceiling)
		expected = ref_ceiling;
	return expected;
endfunction

`endif

//--- verification/throttle_path_tb.sv
// throttle path testbench
`timescale 1ns/100ps

module throttle_path_tb;

	localparam int clk_period = 4;
	localparam int num_samples = 300;
	// worst case per sample plus reset and drain
	localparam int timeout_cycles = num_samples * (50 + 2 * drone_pkg::pwm_period) + 1000;

	logic us_clk;
	logic resetn;
	logic in_req;
	logic in_ack;
	drone_pkg::throttle_t in_throttle;
	logic cfg_write;
	logic [1:0] cfg_addr;
	drone_pkg::throttle_t cfg_data;
	drone_pkg::throttle_t motor_throttle;
	logic pwm_out;

	int errors = 0;
	int checks = 0;
	logic [31:0] rng;
	// handshake levels seen at the previous edge
	logic ack_seen;
	logic req_seen;
	// model motor throttle for the latest accepted sample
	int expected_throttle;

	`include "throttle_model.svh"

	throttle_path_top throttle_path_top_i (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.in_req         (in_req),
		.in_ack         (in_ack),
		.in_throttle    (in_throttle),
		.cfg_write      (cfg_write),
		.cfg_addr       (cfg_addr),
		.cfg_data       (cfg_data),
		.motor_throttle (motor_throttle),
		.pwm_out        (pwm_out)
	);

	always #(clk_period / 2) us_clk = ~us_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %0d expected %0d",
				$time, what, actual, expected);
		end
	endtask

	// one register write, mirrored into the model once it has landed
	task automatic write_config(input logic [1:0] addr, input drone_pkg::throttle_t data);
		@(posedge us_clk);
		cfg_write <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= data;
		@(posedge us_clk);
		cfg_write <= 1'b0;
		case (addr)
			drone_pkg::addr_idle:    ref_idle = data;
			drone_pkg::addr_ceiling: ref_ceiling = data;
			drone_pkg::addr_bypass:  ref_bypass = data[0];
			default: ;
		endcase
	endtask

	// full four-phase cycle, req held for hold edges after ack
	task automatic send_sample(input drone_pkg::throttle_t value, input int hold);
		int expected;
		expected = predict_throttle(value);
		expected_throttle = expected;
		@(posedge us_clk);
		in_throttle <= value;
		in_req <= 1'b1;
		do @(posedge us_clk); while (in_ack !== 1'b1);
		// motor register loads on the same edge that raises ack
		check_value(motor_throttle, expected, "motor_throttle after sample");
		repeat (hold) @(posedge us_clk);
		check_value(in_ack, 1'b1, "in_ack while in_req still high");
		in_req <= 1'b0;
		do @(posedge us_clk); while (in_ack !== 1'b0);
	endtask

	// count pwm high cycles over one frame once the duty has settled
	task automatic measure_duty();
		int high_count;
		high_count = 0;
		repeat (2 * drone_pkg::pwm_period) @(posedge us_clk);
		repeat (drone_pkg::pwm_period) begin
			@(posedge us_clk);
			if (pwm_out === 1'b1)
				high_count++;
		end
		check_value(high_count, expected_throttle, "pwm high cycles per frame");
	endtask

	// ack may rise only with req high and fall only after req fell
	always @(posedge us_clk) begin
		if (resetn === 1'b1) begin
			if (in_ack === 1'b1 && ack_seen === 1'b0)
				check_value(req_seen, 1'b1, "in_ack rose with in_req low");
			if (in_ack === 1'b0 && ack_seen === 1'b1)
				check_value(req_seen, 1'b0, "in_ack fell with in_req high");
		end
		ack_seen <= in_ack;
		req_seen <= in_req;
	end

	initial begin
		drone_pkg::throttle_t value;
		drone_pkg::throttle_t data;
		logic [1:0] addr;
		int hold;
		int gap;
		us_clk = 1'b0;
		resetn = 1'b0;
		in_req = 1'b0;
		in_throttle = '0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		ack_seen = 1'b0;
		req_seen = 1'b0;
		expected_throttle = 0;
		rng = 32'h98af_1af1;
		load_defaults();
		repeat (3) @(posedge us_clk);
		resetn <= 1'b1;
		@(posedge us_clk);
		check_value(in_ack, 1'b0, "in_ack after reset");
		check_value(motor_throttle, 0, "motor_throttle after reset");
		check_value(pwm_out, 1'b0, "pwm_out after reset");
		for (int n = 0; n < num_samples; n++) begin
			rng = xorshift(rng);
			// roughly one sample in eight is preceded by a register write
			if (rng[2:0] == 3'd0) begin
				rng = xorshift(rng);
				addr = rng[9:8];
				case (addr)
					drone_pkg::addr_idle:    data = drone_pkg::throttle_t'(rng[23:16] % 48);
					drone_pkg::addr_ceiling: data = drone_pkg::throttle_t'(64 + rng[23:16] % 192);
					drone_pkg::addr_bypass:  data = {7'd0, rng[16]};
					default:                 data = rng[23:16];
				endcase
				write_config(addr, data);
				rng = xorshift(rng);
			end
			// a quarter of the samples land under the idle threshold
			if (rng[4:3] == 2'd0 && ref_idle > 0)
				value = drone_pkg::throttle_t'(rng[15:8] % ref_idle);
			else
				value = rng[15:8];
			// at least one edge of req held high after ack
			hold = 1 + int'(rng[25:24]);
			gap = int'(rng[30:28]);
			send_sample(value, hold);
			repeat (gap) @(posedge us_clk);
			if (n % 8 == 7)
				measure_duty();
		end
		$display("run done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	initial begin
		#(timeout_cycles * clk_period);
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+verification
verilog/drone_pkg.sv
verilog/limiter_if.sv
verilog/throttle_input_port.sv
verilog/limiter_config.sv
verilog/throttle_change_limiter.sv
verilog/motor_pwm.sv
verilog/throttle_path_top.sv
verification/throttle_path_tb.sv

//--- Makefile
TOP = throttle_path_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
